//--- sources.f
+incdir+design
design/fe_pkg.sv
design/fe_cmd_decode.sv
design/fe_pc_gen.sv
design/fe_fetch_ctrl.sv
design/fe_queue_fmt.sv
design/fe_top.sv
tests/fe_tb_clock.sv
tests/fe_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := fe_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/fe_tb.sv
// Fetch front end testbench
`timescale 1ns/1ps
`default_nettype none

`include "fe_params.svh"

module fe_tb
  import fe_pkg::*;
;

  localparam vaddr_t start_pc = 39'h40_0000_1000;
  localparam vaddr_t reset_pc = 39'h40_0000_8000;
  localparam vaddr_t miss_lo  = 39'h40_0001_0000;
  localparam vaddr_t miss_hi  = 39'h40_0001_00ff;
  localparam vaddr_t fault_lo = 39'h40_0001_00c0;
  localparam vaddr_t fault_hi = 39'h40_0001_01ff;

  logic clk_i, reset_i;
  logic fe_cmd_v_i, fe_queue_ready_i, imem_data_v_i, imem_fault_i;
  fe_cmd_op_e fe_cmd_op_i;
  vaddr_t fe_cmd_vaddr_i, imem_addr_o, fe_queue_pc_o;
  instr_t imem_data_i, fe_queue_instr_o;
  logic imem_v_o, fe_queue_v_o;
  fe_msg_type_e fe_queue_type_o;
  fe_exc_code_e fe_queue_exc_o;

  // Testbench state shared between processes
  string test_name = "reset";
  int cmd_seq = 0;
  int seen_seq = 0;
  int msg_count = 0;
  int exc_count = 0;
  logic quiet = 1'b1;
  logic rand_ready = 1'b0;
  integer seed;
  logic [31:0] rnd;
  vaddr_t cmd_target, exp_pc, last_pc, req_addr;
  logic req_v;
  fe_msg_type_e exp_type;
  fe_exc_code_e exp_exc, last_exc;
  instr_t exp_instr;

  fe_tb_clock i_clock (.clk_o(clk_i), .reset_o(reset_i));

  fe_top i_dut (.*);

  function automatic instr_t instr_hash(input vaddr_t a);
    instr_t h;
    h = a[31:0] ^ {a[38:32], a[31:7]};
    h = h * 32'h9e3779b1;
    return h ^ (h >> 15);
  endfunction

  function automatic logic in_miss_range(input vaddr_t a);
    return (a >= miss_lo) && (a <= miss_hi);
  endfunction

  function automatic logic in_fault_range(input vaddr_t a);
    return (a >= fault_lo) && (a <= fault_hi);
  endfunction

  // Reference model of one queue message
  function automatic void expected_msg(input vaddr_t pc, output fe_msg_type_e t,
                                       output fe_exc_code_e e, output instr_t i);
    t = e_msg_fetch;
    e = e_exc_access_fault;
    i = instr_hash(pc);
    if (in_fault_range(pc) || in_miss_range(pc)) begin
      t = e_msg_exception;
      e = in_fault_range(pc) ? e_exc_access_fault : e_exc_icache_miss;
      i = '0;
    end
  endfunction

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      stop_on_error($sformatf("MISMATCH %s: expected %h actual %h", name, expected, actual));
    end
  endtask

  // Memory answers one cycle after the request
  always @(negedge clk_i) begin
    req_v = imem_v_o;
    req_addr = imem_addr_o;
  end

  initial begin
    imem_data_i = '0;
    imem_data_v_i = 1'b1;
    imem_fault_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      imem_data_i = (req_v === 1'b1) ? instr_hash(req_addr) : '0;
      imem_data_v_i = (req_v === 1'b1) ? !in_miss_range(req_addr) : 1'b1;
      imem_fault_i = (req_v === 1'b1) ? in_fault_range(req_addr) : 1'b0;
    end
  end

  initial begin
    seed = 32'he3d8;
    fe_queue_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      #1;
      rnd = $random(seed);
      fe_queue_ready_i = rand_ready ? (rnd[1:0] != 2'b00) : 1'b1;
    end
  end

  // Compare every accepted message against the reference
  always @(negedge clk_i) begin
    if (cmd_seq != seen_seq) begin
      seen_seq = cmd_seq;
      exp_pc = cmd_target;
      quiet = 1'b0;
    end
    // No fetch goes out while no command is pending
    if (!reset_i && quiet) begin
      check_value({test_name, " imem_v"}, 64'd0, 64'(imem_v_o));
    end
    if (!reset_i && fe_queue_v_o === 1'b1) begin
      if (quiet) begin
        stop_on_error($sformatf("Unexpected queue message with pc %h in test %s",
                                fe_queue_pc_o, test_name));
      end
      expected_msg(exp_pc, exp_type, exp_exc, exp_instr);
      check_value({test_name, " pc"}, 64'(exp_pc), 64'(fe_queue_pc_o));
      check_value({test_name, " type"}, 64'(exp_type), 64'(fe_queue_type_o));
      check_value({test_name, " instr"}, 64'(exp_instr), 64'(fe_queue_instr_o));
      if (exp_type == e_msg_exception) begin
        check_value({test_name, " exc"}, 64'(exp_exc), 64'(fe_queue_exc_o));
        quiet = 1'b1;
        exc_count = exc_count + 1;
      end
      last_pc = fe_queue_pc_o;
      last_exc = fe_queue_exc_o;
      msg_count = msg_count + 1;
      exp_pc = exp_pc + vaddr_t'(`FE_PC_STEP);
    end
  end

  task automatic send_cmd(input fe_cmd_op_e op, input vaddr_t addr);
    @(posedge clk_i);
    #1;
    fe_cmd_v_i = 1'b1;
    fe_cmd_op_i = op;
    fe_cmd_vaddr_i = addr;
    cmd_target = addr;
    cmd_seq = cmd_seq + 1;
    @(posedge clk_i);
    #1;
    fe_cmd_v_i = 1'b0;
  endtask

  task automatic wait_for_msgs(input int n);
    int target;
    int cycles;
    target = msg_count + n;
    cycles = 0;
    while (msg_count < target) begin
      @(posedge clk_i);
      cycles = cycles + 1;
      if (cycles > n * 10 + 50) begin
        stop_on_error($sformatf("Timed out waiting for queue messages in test %s", test_name));
      end
    end
  endtask

  task automatic wait_for_exc();
    int target;
    int cycles;
    target = exc_count + 1;
    cycles = 0;
    while (exc_count < target) begin
      @(posedge clk_i);
      cycles = cycles + 1;
      if (cycles > 200) begin
        stop_on_error($sformatf("No exception message arrived in test %s", test_name));
      end
    end
  endtask

  initial begin
    int cycles;
    int base;
    fe_cmd_v_i = 1'b0;
    fe_cmd_op_i = e_op_state_reset;
    fe_cmd_vaddr_i = '0;
    cycles = 0;
    while (reset_i !== 1'b0) begin
      @(posedge clk_i);
      cycles = cycles + 1;
      if (cycles > 50) begin
        stop_on_error("Reset was never released");
      end
    end

    test_name = "idle_after_reset";
    repeat (20) @(posedge clk_i);
    check_value(test_name, 64'd0, 64'(msg_count));

    test_name = "redirect_sequence";
    send_cmd(e_op_pc_redirect, start_pc);
    wait_for_msgs(16);

    test_name = "random_ready";
    rand_ready = 1'b1;
    wait_for_msgs(40);

    test_name = "state_reset";
    send_cmd(e_op_state_reset, reset_pc);
    wait_for_msgs(1);
    check_value(test_name, 64'(reset_pc), 64'(last_pc));
    wait_for_msgs(8);

    test_name = "icache_miss";
    send_cmd(e_op_pc_redirect, miss_lo - vaddr_t'(16));
    wait_for_exc();
    check_value(test_name, 64'(e_exc_icache_miss), 64'(last_exc));
    check_value(test_name, 64'(miss_lo), 64'(last_pc));
    base = msg_count;
    repeat (20) @(posedge clk_i);
    check_value(test_name, 64'(base), 64'(msg_count));

    // Fault and miss overlap here
    test_name = "access_fault";
    send_cmd(e_op_pc_redirect, fault_lo);
    wait_for_exc();
    check_value(test_name, 64'(e_exc_access_fault), 64'(last_exc));
    check_value(test_name, 64'(fault_lo), 64'(last_pc));

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/fe_tb_clock.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module fe_tb_clock (
  output logic clk_o,
  output logic reset_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (8) @(posedge clk_o);
    #1;
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- design/fe_top.sv
// Instruction fetch front end
`timescale 1ns/1ps
`default_nettype none

module fe_top
  import fe_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic         fe_cmd_v_i,
  input  fe_cmd_op_e   fe_cmd_op_i,
  input  vaddr_t       fe_cmd_vaddr_i,
  input  logic         fe_queue_ready_i,
  input  instr_t       imem_data_i,
  input  logic         imem_data_v_i,
  input  logic         imem_fault_i,
  output logic         imem_v_o,
  output vaddr_t       imem_addr_o,
  output logic         fe_queue_v_o,
  output fe_msg_type_e fe_queue_type_o,
  output fe_exc_code_e fe_queue_exc_o,
  output vaddr_t       fe_queue_pc_o,
  output instr_t       fe_queue_instr_o
);

  logic   advance;
  logic   redirect_v;
  vaddr_t resume_pc;
  vaddr_t next_pc;
  vaddr_t fetch_pc;
  logic   cmd_any_v;
  logic   cmd_redirect_v;
  logic   cmd_stall_v;
  logic   fetch_fail;
  logic   v_if2;
  logic   exception_v;

  fe_cmd_decode i_cmd_decode (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fe_cmd_v_i     (fe_cmd_v_i),
    .fe_cmd_op_i    (fe_cmd_op_i),
    .fe_cmd_vaddr_i (fe_cmd_vaddr_i),
    .fetch_pc_i     (fetch_pc),
    .advance_i      (advance),
    .fetch_fail_i   (fetch_fail),
    .cmd_any_o      (cmd_any_v),
    .cmd_redirect_o (cmd_redirect_v),
    .cmd_stall_o    (cmd_stall_v),
    .redirect_v_o   (redirect_v),
    .resume_pc_o    (resume_pc)
  );

  fe_pc_gen i_pc_gen (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .advance_i    (advance),
    .redirect_v_i (redirect_v),
    .resume_pc_i  (resume_pc),
    .next_pc_o    (next_pc),
    .fetch_pc_o   (fetch_pc)
  );

  fe_fetch_ctrl i_fetch_ctrl (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .cmd_any_i          (cmd_any_v),
    .cmd_redirect_i     (cmd_redirect_v),
    .cmd_stall_i        (cmd_stall_v),
    .exception_v_i      (exception_v),
    .fe_queue_ready_i   (fe_queue_ready_i),
    .imem_data_v_i      (imem_data_v_i),
    .advance_o          (advance),
    .redirect_pending_o (),
    .v_if2_o            (v_if2),
    .fetch_fail_o       (fetch_fail),
    .fe_queue_v_o       (fe_queue_v_o)
  );

  fe_queue_fmt i_queue_fmt (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .imem_fault_i     (imem_fault_i),
    .imem_data_v_i    (imem_data_v_i),
    .imem_data_i      (imem_data_i),
    .v_if2_i          (v_if2),
    .fetch_pc_i       (fetch_pc),
    .exception_v_o    (exception_v),
    .fe_queue_type_o  (fe_queue_type_o),
    .fe_queue_exc_o   (fe_queue_exc_o),
    .fe_queue_pc_o    (fe_queue_pc_o),
    .fe_queue_instr_o (fe_queue_instr_o)
  );

  assign imem_v_o    = advance;
  assign imem_addr_o = next_pc;

endmodule

`default_nettype wire

//--- design/fe_queue_fmt.sv
// Fetch queue message former
`timescale 1ns/1ps
`default_nettype none

module fe_queue_fmt
  import fe_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic         imem_fault_i,
  input  logic         imem_data_v_i,
  input  instr_t       imem_data_i,
  input  logic         v_if2_i,
  input  vaddr_t       fetch_pc_i,
  output logic         exception_v_o,
  output fe_msg_type_e fe_queue_type_o,
  output fe_exc_code_e fe_queue_exc_o,
  output vaddr_t       fe_queue_pc_o,
  output instr_t       fe_queue_instr_o
);

  logic         fault_v;
  logic         miss_v;
  fe_msg_type_e type_n;
  fe_exc_code_e exc_n;
  instr_t       instr_n;
  fe_msg_type_e type_r;
  fe_exc_code_e exc_r;
  vaddr_t       pc_r;
  instr_t       instr_r;

  assign fault_v       = v_if2_i & imem_fault_i;
  assign miss_v        = v_if2_i & ~imem_data_v_i;
  assign exception_v_o = fault_v | miss_v;

  // Access fault outranks a miss
  assign exc_n   = imem_fault_i ? e_exc_access_fault : e_exc_icache_miss;
  assign type_n  = exception_v_o ? e_msg_exception : e_msg_fetch;
  assign instr_n = exception_v_o ? '0 : imem_data_i;

  // Last message fields hold while IF2 is empty
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      type_r <= e_msg_fetch;
      exc_r  <= e_exc_access_fault;
    end else if (v_if2_i) begin
      type_r <= type_n;
      exc_r  <= exc_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_if2_i) begin
      pc_r    <= fetch_pc_i;
      instr_r <= instr_n;
    end
  end

  assign fe_queue_type_o  = v_if2_i ? type_n : type_r;
  assign fe_queue_exc_o   = v_if2_i ? exc_n : exc_r;
  assign fe_queue_pc_o    = v_if2_i ? fetch_pc_i : pc_r;
  assign fe_queue_instr_o = v_if2_i ? instr_n : instr_r;

endmodule

`default_nettype wire

//--- design/fe_fetch_ctrl.sv
// Fetch pipeline controller
`timescale 1ns/1ps
`default_nettype none

module fe_fetch_ctrl
  import fe_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic cmd_any_i,
  input  logic cmd_redirect_i,
  input  logic cmd_stall_i,
  input  logic exception_v_i,
  input  logic fe_queue_ready_i,
  input  logic imem_data_v_i,
  output logic advance_o,
  output logic redirect_pending_o,
  output logic v_if2_o,
  output logic fetch_fail_o,
  output logic fe_queue_v_o
);

  fe_state_e state_r;
  fe_state_e state_n;
  logic      v_if1;
  logic      v_if2_r;
  logic      stall;
  logic      unstall;
  logic      exception_sent;

  // IF1 is valid whenever an address goes out
  assign v_if1 = advance_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_if2_r <= 1'b0;
    end else begin
      v_if2_r <= v_if1;
    end
  end

  // Any command squashes the word in IF2
  assign v_if2_o      = v_if2_r & ~cmd_any_i;
  assign fe_queue_v_o = v_if2_o & fe_queue_ready_i & (imem_data_v_i | exception_v_i);
  assign fetch_fail_o = v_if2_o & ~fe_queue_v_o;

  assign exception_sent = fe_queue_v_o & exception_v_i;
  assign stall          = fetch_fail_o | cmd_stall_i;
  assign unstall        = fe_queue_ready_i & ~cmd_any_i;

  always_comb begin
    case (state_r)
      e_wait: begin
        state_n = cmd_redirect_i ? e_run : (cmd_stall_i ? e_stall : e_wait);
      end
      e_stall: begin
        state_n = (cmd_redirect_i | unstall) ? e_run : e_stall;
      end
      // Redirect keeps running; exceptions park the pipeline until a command
      e_run: begin
        if (cmd_redirect_i) begin
          state_n = e_run;
        end else if (stall) begin
          state_n = e_stall;
        end else if (exception_sent) begin
          state_n = e_wait;
        end else begin
          state_n = e_run;
        end
      end
      default: state_n = e_wait;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_wait;
    end else begin
      state_r <= state_n;
    end
  end

  assign advance_o          = (state_n == e_run);
  assign redirect_pending_o = (state_r == e_stall);

endmodule

`default_nettype wire

//--- design/fe_pc_gen.sv
// Fetch PC generation
`timescale 1ns/1ps
`default_nettype none

`include "fe_params.svh"

module fe_pc_gen
  import fe_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   advance_i,
  input  logic   redirect_v_i,
  input  vaddr_t resume_pc_i,
  output vaddr_t next_pc_o,
  output vaddr_t fetch_pc_o
);

  // IF1 pc is the address issued this cycle
  vaddr_t pc_if1;
  // IF2 pc belongs to the word coming back from memory
  vaddr_t pc_if2_r;

  assign pc_if1 = redirect_v_i ? resume_pc_i : pc_if2_r + vaddr_t'(`FE_PC_STEP);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_if2_r <= '0;
    end else if (advance_i) begin
      pc_if2_r <= pc_if1;
    end
  end

  assign next_pc_o  = pc_if1;
  assign fetch_pc_o = pc_if2_r;

endmodule

`default_nettype wire

//--- design/fe_cmd_decode.sv
// Command decode and resume PC
`timescale 1ns/1ps
`default_nettype none

module fe_cmd_decode
  import fe_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       fe_cmd_v_i,
  input  fe_cmd_op_e fe_cmd_op_i,
  input  vaddr_t     fe_cmd_vaddr_i,
  input  vaddr_t     fetch_pc_i,
  input  logic       advance_i,
  input  logic       fetch_fail_i,
  output logic       cmd_any_o,
  output logic       cmd_redirect_o,
  output logic       cmd_stall_o,
  output logic       redirect_v_o,
  output vaddr_t     resume_pc_o
);

  logic   state_reset_v;
  logic   wait_v;
  logic   resume_en;
  vaddr_t resume_n;
  vaddr_t resume_r;
  logic   restart_r;

  assign state_reset_v  = fe_cmd_v_i & (fe_cmd_op_i == e_op_state_reset);
  assign wait_v         = fe_cmd_v_i & (fe_cmd_op_i == e_op_wait);
  assign cmd_redirect_o = fe_cmd_v_i & (fe_cmd_op_i == e_op_pc_redirect);
  assign cmd_stall_o    = state_reset_v | wait_v;
  assign cmd_any_o      = cmd_redirect_o | cmd_stall_o;

  // Wait keeps the pc squashed in IF2, so fetch picks up where it left off
  assign resume_n  = (state_reset_v | cmd_redirect_o) ? fe_cmd_vaddr_i : fetch_pc_i;
  assign resume_en = cmd_any_o | fetch_fail_i;

  always_ff @(posedge clk_i) begin
    if (resume_en) begin
      resume_r <= resume_n;
    end
  end

  // Bypass lets a redirect issue its vaddr in the command cycle
  assign resume_pc_o = resume_en ? resume_n : resume_r;

  // First issue after a stall restarts from the resume pc
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      restart_r <= 1'b0;
    end else if (advance_i) begin
      restart_r <= 1'b0;
    end else if (cmd_stall_o | fetch_fail_i) begin
      restart_r <= 1'b1;
    end
  end

  assign redirect_v_o = cmd_redirect_o | (restart_r & advance_i);

endmodule

`default_nettype wire

//--- design/fe_pkg.sv
// Fetch front end types
`default_nettype none

`include "fe_params.svh"

package fe_pkg;

  typedef logic [`FE_VADDR_WIDTH-1:0] vaddr_t;
  typedef logic [`FE_INSTR_WIDTH-1:0] instr_t;

  // Back end command opcodes
  typedef enum logic [1:0] {
    e_op_state_reset = 2'd0,
    e_op_pc_redirect = 2'd1,
    e_op_wait        = 2'd2
  } fe_cmd_op_e;

  typedef enum logic [0:0] {
    e_msg_fetch     = 1'b0,
    e_msg_exception = 1'b1
  } fe_msg_type_e;

  typedef enum logic [1:0] {
    e_exc_access_fault = 2'd0,
    e_exc_icache_miss  = 2'd1
  } fe_exc_code_e;

  // Fetch controller states
  typedef enum logic [1:0] {
    e_wait  = 2'd0,
    e_run   = 2'd1,
    e_stall = 2'd2
  } fe_state_e;

endpackage

`default_nettype wire

//--- design/fe_params.svh
// Fetch front end parameters
`ifndef FE_PARAMS_SVH
`define FE_PARAMS_SVH

// Virtual fetch address width
`define FE_VADDR_WIDTH 39

// Instruction word width
`define FE_INSTR_WIDTH 32

// Byte distance between sequential fetches
`define FE_PC_STEP 4

`endif
